// File: fpga_core.f
pcie_tlp_pkg.sv
core_pkg.sv
rx_seg_unpack.sv
tlp_req_decode.sv
bar_reg_cpl.sv
fpga_core.sv
fpga_core_chk.sv
tb_fpga_core.sv

// File: run_sim.sh
#!/bin/sh
# build the fpga_core testbench with Verilator, run it and scan the log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_fpga_core \
    -f fpga_core.f || exit 1

./obj_dir/Vtb_fpga_core > sim.log 2>&1
sim_status=$?
cat sim.log

grep -q "Checks failed" sim.log && exit 1
[ "$sim_status" -eq 0 ] && grep -q "All checks passed" sim.log || exit 1
exit 0

// File: fpga_core_stim.txt
// op seg bar 4dw wr addr data be tag status expected (all hex)
// op 0 new beat, 1 joins previous beat, 2 bus number in data, 3 user_led check in expected
0 0 0 0 1 00000004 12345678 f 01 0 00000000
0 0 0 0 0 00000004 00000000 f 02 0 12345678
0 1 0 1 1 00000020 cafef00d f 03 0 00000000
0 1 0 1 0 00000020 00000000 f 04 0 cafef00d
0 0 0 0 1 00000004 aabbccdd 5 05 0 00000000
0 0 0 0 0 00000004 00000000 c 06 0 12bb56dd
0 1 0 0 1 00000004 00ff0000 8 07 0 00000000
0 1 0 0 0 00000004 00000000 f 08 0 00bb56dd
0 0 2 0 0 00000004 00000000 f 09 1 00000000
0 1 0 0 0 00000040 00000000 f 0a 1 00000000
0 0 2 0 1 00000004 deadbeef f 0b 0 00000000
0 1 0 0 1 00000044 deadbeef f 0c 0 00000000
0 0 0 0 0 00000004 00000000 f 0d 0 00bb56dd
0 0 0 0 1 00000008 11111111 f 0e 0 00000000
1 1 0 0 1 00000008 22222222 f 0f 0 00000000
0 0 0 0 0 00000008 00000000 f 10 0 22222222
1 1 0 0 0 00000008 00000000 f 11 0 22222222
0 0 0 0 0 00000008 00000000 f 12 0 22222222
1 1 0 0 1 00000008 33333333 f 13 0 00000000
0 1 0 1 0 00000008 00000000 f 14 0 33333333
2 0 0 0 0 00000000 000000a5 0 00 0 00000000
0 0 0 0 1 00000000 0000000b 1 15 0 00000000
0 1 0 0 0 00000000 00000000 f 16 0 0000000b
3 0 0 0 0 00000000 00000000 0 00 0 0000000b
0 0 0 0 1 00000000 00000006 f 17 0 00000000
0 1 0 1 0 00000000 00000000 2 18 0 00000006
3 0 0 0 0 00000000 00000000 0 00 0 00000006

// File: tb_fpga_core.sv
// fpga_core testbench with file-driven requests, completion scoreboard and LED checks
// tx_st_ready gaps come from a Galois LFSR

`timescale 1ns/1ps

module tb_fpga_core;

    localparam int SEG_COUNT = 2;
    localparam int SEG_DATA_WIDTH = 256;
    localparam int BRW = core_pkg::BAR_RANGE_WIDTH;
    // stimulus record layout
    localparam int NUM_FIELDS = 11;
    localparam int MAX_RECS = 64;
    localparam int F_OP = 0;
    localparam int F_SEG = 1;
    localparam int F_BAR = 2;
    localparam int F_4DW = 3;
    localparam int F_WR = 4;
    localparam int F_ADDR = 5;
    localparam int F_DATA = 6;
    localparam int F_BE = 7;
    localparam int F_TAG = 8;
    localparam int F_STS = 9;
    localparam int F_EXP = 10;
    localparam logic [31:0] OP_JOIN = 32'd1;
    localparam logic [31:0] OP_BUS = 32'd2;
    localparam logic [31:0] OP_LED = 32'd3;
    // requester bus 1 device 0 function 0
    localparam logic [15:0] REQ_ID = 16'h0100;
    localparam logic [31:0] ADDR_HI = 32'h0000_0001;
    localparam logic [15:0] LFSR_TAPS = 16'hb400;

    typedef struct packed {
        logic [7:0]             seg;
        pcie_tlp_pkg::tlp_dw0_t dw0;
        pcie_tlp_pkg::tlp_dw1_u dw1;
        pcie_tlp_pkg::cpl_dw2_t dw2;
        logic [31:0]            data;
    } cpl_rec_t;

    logic                               clk;
    logic                               rst_n;
    logic [3:0]                         user_led;
    logic [SEG_COUNT*SEG_DATA_WIDTH-1:0] rx_st_data;
    logic [SEG_COUNT-1:0]               rx_st_sop;
    logic [SEG_COUNT-1:0]               rx_st_eop;
    logic [SEG_COUNT-1:0]               rx_st_valid;
    logic [SEG_COUNT*BRW-1:0]           rx_st_bar_range;
    logic                               rx_st_ready;
    logic [SEG_COUNT*SEG_DATA_WIDTH-1:0] tx_st_data;
    logic [SEG_COUNT-1:0]               tx_st_sop;
    logic [SEG_COUNT-1:0]               tx_st_eop;
    logic [SEG_COUNT-1:0]               tx_st_valid;
    logic                               tx_st_ready = 1'b1;
    logic [31:0]                        tl_cfg_ctl;
    logic [4:0]                         tl_cfg_add;
    logic [1:0]                         tl_cfg_func;

    logic [31:0] stim_mem [NUM_FIELDS*MAX_RECS];
    // expected completions in issue order
    cpl_rec_t    exp_q[$];
    // beat being assembled before it is driven
    logic [SEG_COUNT*SEG_DATA_WIDTH-1:0] beat_data;
    logic [SEG_COUNT*BRW-1:0]           beat_bar;
    logic [SEG_COUNT-1:0]               beat_mask;
    logic [7:0]  cur_bus = 8'd0;
    logic [15:0] lfsr_state = 16'd41962;
    int          cycle_count = 0;
    int          cycle_limit = 1000;
    int          cpl_err_count = 0;
    int          sb_err_count = 0;
    int          led_err_count = 0;
    int          stim_err_count = 0;

    fpga_core fpga_core_inst (
        .clk(clk),
        .rst_n(rst_n),
        .user_led(user_led),
        .rx_st_data(rx_st_data),
        .rx_st_sop(rx_st_sop),
        .rx_st_eop(rx_st_eop),
        .rx_st_valid(rx_st_valid),
        .rx_st_bar_range(rx_st_bar_range),
        .rx_st_ready(rx_st_ready),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready),
        .tl_cfg_ctl(tl_cfg_ctl),
        .tl_cfg_add(tl_cfg_add),
        .tl_cfg_func(tl_cfg_func)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ LFSR_TAPS;
        end
        return state >> 1;
    endfunction

    // lowest enabled byte gives the low address bits
    function automatic logic [1:0] first_byte(input logic [3:0] be);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                return 2'(b);
            end
        end
        return 2'd0;
    endfunction

    // one LFSR bit per cycle gates the link
    always @(posedge clk) begin
        tx_st_ready <= lfsr_state[0];
        lfsr_state  <= lfsr_step(lfsr_state);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d completions missing",
                     cycle_count, exp_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_cpl(input cpl_rec_t got, input cpl_rec_t exp);
        logic has_data;
        has_data = (exp.dw0.fmt_type == pcie_tlp_pkg::TLP_CPLD);
        if (got.dw0 !== exp.dw0 || got.dw1 !== exp.dw1 || got.dw2 !== exp.dw2 ||
            (has_data && got.data !== exp.data)) begin
            cpl_err_count++;
            $display("** Error at %0t: cpl tag %h got %h %h %h %h, exp %h %h %h %h",
                     $time, exp.dw2.tag, got.dw0, got.dw1, got.dw2, got.data,
                     exp.dw0, exp.dw1, exp.dw2, exp.data);
        end
    endtask

    task automatic check_led(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            led_err_count++;
            $display("** Error at %0t: user_led %h, expected %h", $time, got, exp);
        end
    endtask

    // match a taken completion by tag, it must be the oldest of its segment
    task automatic take_cpl(input int s);
        logic [127:0] lanes;
        cpl_rec_t     got;
        int           idx;
        int           first_idx;
        lanes     = tx_st_data[s*SEG_DATA_WIDTH +: 128];
        got.seg   = 8'(s);
        got.dw0   = pcie_tlp_pkg::tlp_dw0_t'(lanes[31:0]);
        got.dw1   = pcie_tlp_pkg::tlp_dw1_u'(lanes[63:32]);
        got.dw2   = pcie_tlp_pkg::cpl_dw2_t'(lanes[95:64]);
        got.data  = lanes[127:96];
        idx       = -1;
        first_idx = -1;
        if (!(tx_st_sop[s] && tx_st_eop[s])) begin
            sb_err_count++;
            $display("completion on segment %0d lacks sop or eop at %0t", s, $time);
        end
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i].dw2.tag == got.dw2.tag) begin
                idx = i;
            end
            if (first_idx < 0 && exp_q[i].seg == 8'(s)) begin
                first_idx = i;
            end
        end
        if (idx < 0) begin
            sb_err_count++;
            $display("unexpected completion with tag %h on segment %0d", got.dw2.tag, s);
        end else begin
            if (idx != first_idx) begin
                sb_err_count++;
                $display("completion with tag %h came out of order or on the wrong segment",
                         got.dw2.tag);
            end
            check_cpl(got, exp_q[idx]);
            exp_q.delete(idx);
        end
    endtask

    // a beat leaves at the next edge while tx_st_ready is high
    always @(negedge clk) begin
        if (rst_n) begin
            for (int s = 0; s < SEG_COUNT; s++) begin
                if (tx_st_valid[s] && tx_st_ready) begin
                    take_cpl(s);
                end
            end
        end
    end

    // build one request TLP into the beat, queue its completion for reads
    task automatic add_request(input int r);
        logic [31:0]            f [NUM_FIELDS];
        int                     seg;
        logic                   ur;
        logic [159:0]           tlp;
        pcie_tlp_pkg::tlp_dw0_t dw0;
        pcie_tlp_pkg::tlp_dw1_u dw1;
        cpl_rec_t               exp;
        for (int k = 0; k < NUM_FIELDS; k++) begin
            f[k] = stim_mem[r*NUM_FIELDS + k];
        end
        seg = int'(f[F_SEG]);
        ur  = (pcie_tlp_pkg::cpl_status_e'(f[F_STS][2:0]) == pcie_tlp_pkg::CPL_STATUS_UR);
        dw0 = '0;
        if (f[F_WR][0]) begin
            dw0.fmt_type = f[F_4DW][0] ? pcie_tlp_pkg::TLP_MWR64 : pcie_tlp_pkg::TLP_MWR32;
        end else begin
            dw0.fmt_type = f[F_4DW][0] ? pcie_tlp_pkg::TLP_MRD64 : pcie_tlp_pkg::TLP_MRD32;
        end
        dw0.length           = 10'd1;
        dw1.req.requester_id = REQ_ID;
        dw1.req.tag          = f[F_TAG][7:0];
        dw1.req.last_be      = 4'd0;
        dw1.req.first_be     = f[F_BE][3:0];
        // 4DW carries the upper address dword first
        if (f[F_4DW][0]) begin
            tlp = {f[F_DATA], f[F_ADDR], ADDR_HI, dw1, dw0};
        end else begin
            tlp = {32'd0, f[F_DATA], f[F_ADDR], dw1, dw0};
        end
        beat_data[seg*SEG_DATA_WIDTH +: 160] = tlp;
        beat_bar[seg*BRW +: BRW]             = f[F_BAR][BRW-1:0];
        beat_mask[seg]                       = 1'b1;
        if (!f[F_WR][0]) begin
            exp.seg                  = 8'(seg);
            exp.dw0                  = '0;
            exp.dw0.fmt_type         = ur ? pcie_tlp_pkg::TLP_CPL : pcie_tlp_pkg::TLP_CPLD;
            exp.dw0.length           = ur ? 10'd0 : 10'd1;
            exp.dw1.cpl.completer_id = {cur_bus, 8'h00};
            exp.dw1.cpl.status       = ur ? pcie_tlp_pkg::CPL_STATUS_UR
                                          : pcie_tlp_pkg::CPL_STATUS_SC;
            exp.dw1.cpl.bcm          = 1'b0;
            exp.dw1.cpl.byte_count   = 12'd4;
            exp.dw2.requester_id     = REQ_ID;
            exp.dw2.tag              = f[F_TAG][7:0];
            exp.dw2.rsvd             = 1'b0;
            exp.dw2.lower_addr       = {f[F_ADDR][6:2], first_byte(f[F_BE][3:0])};
            exp.data                 = f[F_EXP];
            exp_q.push_back(exp);
        end
    endtask

    task automatic drive_beat();
        @(posedge clk);
        rx_st_data      <= beat_data;
        rx_st_bar_range <= beat_bar;
        rx_st_sop       <= beat_mask;
        rx_st_eop       <= beat_mask;
        rx_st_valid     <= beat_mask;
        // taken at the first edge with rx_st_ready high
        @(negedge clk);
        while (!rx_st_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        rx_st_valid <= '0;
        rx_st_sop   <= '0;
        rx_st_eop   <= '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // bus number rides on tl_cfg_add 0 of function 0
    task automatic set_bus_number(input logic [7:0] bus);
        wait_drain();
        @(posedge clk);
        tl_cfg_func <= 2'd0;
        tl_cfg_add  <= 5'd0;
        tl_cfg_ctl  <= {24'd0, bus};
        @(posedge clk);
        tl_cfg_add  <= 5'd1;
        cur_bus = bus;
    endtask

    initial begin
        int          r;
        int          rec_count;
        logic [31:0] op;
        rx_st_data      = '0;
        rx_st_sop       = '0;
        rx_st_eop       = '0;
        rx_st_valid     = '0;
        rx_st_bar_range = '0;
        tl_cfg_ctl      = 32'd0;
        tl_cfg_add      = 5'd1;
        tl_cfg_func     = 2'd0;
        rst_n           = 1'b0;
        for (int i = 0; i < NUM_FIELDS*MAX_RECS; i++) begin
            stim_mem[i] = '1;
        end
        $readmemh("fpga_core_stim.txt", stim_mem);
        rec_count = 0;
        while (rec_count < MAX_RECS && stim_mem[rec_count*NUM_FIELDS] != '1) begin
            rec_count++;
        end
        if (rec_count == 0) begin
            stim_err_count++;
            $display("no stimulus records could be read");
        end
        cycle_limit = rec_count*20 + 200;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        r = 0;
        while (r < rec_count) begin
            op = stim_mem[r*NUM_FIELDS + F_OP];
            if (op == OP_BUS) begin
                set_bus_number(stim_mem[r*NUM_FIELDS + F_DATA][7:0]);
                r++;
            end else if (op == OP_LED) begin
                // the preceding read shows the write has landed
                wait_drain();
                check_led(user_led, stim_mem[r*NUM_FIELDS + F_EXP][3:0]);
                r++;
            end else begin
                beat_data = '0;
                beat_bar  = '0;
                beat_mask = '0;
                add_request(r);
                r++;
                while (r < rec_count && stim_mem[r*NUM_FIELDS + F_OP] == OP_JOIN) begin
                    add_request(r);
                    r++;
                end
                drive_beat();
            end
        end
        wait_drain();
        repeat (4) @(posedge clk);
        $display("errors: completion %0d, led %0d, scoreboard %0d, stimulus %0d",
                 cpl_err_count, led_err_count, sb_err_count, stim_err_count);
        if (cpl_err_count + led_err_count + sb_err_count + stim_err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: fpga_core_chk.sv
// bound assertions on the fpga_core rx and tx stream interfaces
// reset state of tx, tx hold under back-pressure, rx_st_ready level

`timescale 1ns/1ps

module fpga_core_chk #(
    parameter int SEG_COUNT = 2,
    parameter int SEG_DATA_WIDTH = 256
) (
    input logic                              clk,
    input logic                              rst_n,
    input logic [SEG_COUNT*SEG_DATA_WIDTH-1:0] tx_st_data,
    input logic [SEG_COUNT-1:0]              tx_st_sop,
    input logic [SEG_COUNT-1:0]              tx_st_eop,
    input logic [SEG_COUNT-1:0]              tx_st_valid,
    input logic                              tx_st_ready,
    input logic                              rx_st_ready
);

    // a completion is waiting on the link
    logic held;

    assign held = (|tx_st_valid) && !tx_st_ready;

    // tx comes out of reset idle
    tx_idle_after_reset: assert property (@(posedge clk) !rst_n |=> tx_st_valid == '0)
        else $error("tx_st_valid set in the cycle after reset");

    // held completion keeps its beat
    tx_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
        held |=> $stable(tx_st_data) && $stable(tx_st_sop) && $stable(tx_st_eop) &&
                 $stable(tx_st_valid))
        else $error("tx beat changed while held by tx_st_ready");

    // rx stalls exactly while tx is held
    rx_ready_level: assert property (@(posedge clk) disable iff (!rst_n)
        rx_st_ready == !held)
        else $error("rx_st_ready does not follow the tx hold state");

endmodule

bind fpga_core fpga_core_chk #(
    .SEG_COUNT(SEG_COUNT),
    .SEG_DATA_WIDTH(SEG_DATA_WIDTH)
) fpga_core_chk_inst (
    .clk(clk),
    .rst_n(rst_n),
    .tx_st_data(tx_st_data),
    .tx_st_sop(tx_st_sop),
    .tx_st_eop(tx_st_eop),
    .tx_st_valid(tx_st_valid),
    .tx_st_ready(tx_st_ready),
    .rx_st_ready(rx_st_ready)
);

// File: fpga_core.sv
// PCIe endpoint core top level on the H-tile segmented stream
// unpack register, per-segment decoders and the BAR0 completion block

`timescale 1ns/1ps

module fpga_core #(
    parameter int SEG_COUNT = 2,
    parameter int SEG_DATA_WIDTH = 256
) (
    input  logic                                           clk,
    input  logic                                           rst_n,

    output logic [3:0]                                     user_led,

    // H-tile rx stream
    input  logic [SEG_COUNT*SEG_DATA_WIDTH-1:0]            rx_st_data,
    input  logic [SEG_COUNT-1:0]                           rx_st_sop,
    input  logic [SEG_COUNT-1:0]                           rx_st_eop,
    input  logic [SEG_COUNT-1:0]                           rx_st_valid,
    input  logic [SEG_COUNT*core_pkg::BAR_RANGE_WIDTH-1:0] rx_st_bar_range,
    output logic                                           rx_st_ready,

    // H-tile tx stream
    output logic [SEG_COUNT*SEG_DATA_WIDTH-1:0]            tx_st_data,
    output logic [SEG_COUNT-1:0]                           tx_st_sop,
    output logic [SEG_COUNT-1:0]                           tx_st_eop,
    output logic [SEG_COUNT-1:0]                           tx_st_valid,
    input  logic                                           tx_st_ready,

    // config space export
    input  logic [31:0]                                    tl_cfg_ctl,
    input  logic [4:0]                                     tl_cfg_add,
    input  logic [1:0]                                     tl_cfg_func
);

    core_pkg::rx_seg_t [SEG_COUNT-1:0] seg;
    core_pkg::req_t [SEG_COUNT-1:0]    req;
    core_pkg::tx_seg_t [SEG_COUNT-1:0] tx_seg;
    logic                              advance;

    // whole pipeline moves on one level
    assign rx_st_ready = advance;

    rx_seg_unpack #(
        .SEG_COUNT(SEG_COUNT),
        .SEG_DATA_WIDTH(SEG_DATA_WIDTH)
    ) rx_seg_unpack_inst (
        .clk(clk),
        .rst_n(rst_n),
        .advance(advance),
        .rx_st_data(rx_st_data),
        .rx_st_sop(rx_st_sop),
        .rx_st_eop(rx_st_eop),
        .rx_st_valid(rx_st_valid),
        .rx_st_bar_range(rx_st_bar_range),
        .seg(seg)
    );

    for (genvar s = 0; s < SEG_COUNT; s++) begin : g_seg
        tlp_req_decode #(
            .SEG_DATA_WIDTH(SEG_DATA_WIDTH)
        ) tlp_req_decode_inst (
            .clk(clk),
            .rst_n(rst_n),
            .advance(advance),
            .seg(seg[s]),
            .req(req[s])
        );

        // tx structs back onto the flat buses
        assign tx_st_data[s*SEG_DATA_WIDTH +: SEG_DATA_WIDTH] =
            tx_seg[s].data[SEG_DATA_WIDTH-1:0];
        assign tx_st_sop[s]   = tx_seg[s].sop;
        assign tx_st_eop[s]   = tx_seg[s].eop;
        assign tx_st_valid[s] = tx_seg[s].valid;
    end

    bar_reg_cpl #(
        .SEG_COUNT(SEG_COUNT)
    ) bar_reg_cpl_inst (
        .clk(clk),
        .rst_n(rst_n),
        .req(req),
        .tx_st_ready(tx_st_ready),
        .tl_cfg_ctl(tl_cfg_ctl),
        .tl_cfg_add(tl_cfg_add),
        .tl_cfg_func(tl_cfg_func),
        .tx_seg(tx_seg),
        .advance(advance),
        .user_led(user_led)
    );

endmodule

// File: bar_reg_cpl.sv
// BAR0 register bank, completion builder and tx segment drive
// also pipeline advance, bus number capture and LED output

`timescale 1ns/1ps

module bar_reg_cpl #(
    parameter int SEG_COUNT = 2
) (
    input  logic                               clk,
    input  logic                               rst_n,
    input  core_pkg::req_t [SEG_COUNT-1:0]     req,
    input  logic                               tx_st_ready,
    input  logic [31:0]                        tl_cfg_ctl,
    input  logic [4:0]                         tl_cfg_add,
    input  logic [1:0]                         tl_cfg_func,
    output core_pkg::tx_seg_t [SEG_COUNT-1:0]  tx_seg,
    output logic                               advance,
    output logic [3:0]                         user_led
);

    // register bank
    logic [31:0] regs [core_pkg::REG_COUNT];
    // captured bus number for the completer id
    logic [7:0]  bus_num;

    logic [SEG_COUNT-1:0]                   tx_valid;
    pcie_tlp_pkg::tlp_dw0_t [SEG_COUNT-1:0] cpl_dw0;
    pcie_tlp_pkg::tlp_dw1_u [SEG_COUNT-1:0] cpl_dw1;
    pcie_tlp_pkg::cpl_dw2_t [SEG_COUNT-1:0] cpl_dw2;
    logic [SEG_COUNT-1:0][31:0]             rd_data;
    core_pkg::tx_seg_t [SEG_COUNT-1:0]      cpl_d;

    always_comb begin
        for (int s = 0; s < SEG_COUNT; s++) begin
            tx_valid[s] = tx_seg[s].valid;
        end
    end

    // stall only while a completion is held by the link
    assign advance = !(|tx_valid) || tx_st_ready;

    // one completion per read, misses get UR without data
    always_comb begin
        for (int s = 0; s < SEG_COUNT; s++) begin
            cpl_dw0[s]          = '0;
            cpl_dw0[s].fmt_type = req[s].hit ? pcie_tlp_pkg::TLP_CPLD : pcie_tlp_pkg::TLP_CPL;
            cpl_dw0[s].length   = req[s].hit ? 10'd1 : 10'd0;

            // completion view of dword 1, device 0 function 0
            cpl_dw1[s].cpl.completer_id = {bus_num, 5'd0, 3'd0};
            cpl_dw1[s].cpl.status       = req[s].hit ? pcie_tlp_pkg::CPL_STATUS_SC
                                                     : pcie_tlp_pkg::CPL_STATUS_UR;
            cpl_dw1[s].cpl.bcm          = 1'b0;
            cpl_dw1[s].cpl.byte_count   = 12'd4;

            cpl_dw2[s].requester_id = req[s].requester_id;
            cpl_dw2[s].tag          = req[s].tag;
            cpl_dw2[s].rsvd         = 1'b0;
            cpl_dw2[s].lower_addr   = req[s].lower_addr;

            // old register value, writes land at the same edge
            rd_data[s] = req[s].hit ? regs[req[s].reg_index] : 32'd0;

            cpl_d[s].data        = '0;
            cpl_d[s].data[127:0] = {rd_data[s], cpl_dw2[s], cpl_dw1[s], cpl_dw0[s]};
            cpl_d[s].sop         = 1'b1;
            cpl_d[s].eop         = 1'b1;
            cpl_d[s].valid       = req[s].valid && !req[s].is_write;
        end
    end

    // completion register and byte-enabled writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < core_pkg::REG_COUNT; r++) begin
                regs[r] <= '0;
            end
            for (int s = 0; s < SEG_COUNT; s++) begin
                tx_seg[s].valid <= 1'b0;
            end
        end else if (advance) begin
            tx_seg <= cpl_d;
            // ascending order, so the higher segment wins a clash
            for (int s = 0; s < SEG_COUNT; s++) begin
                if (req[s].valid && req[s].is_write && req[s].hit) begin
                    for (int b = 0; b < 4; b++) begin
                        if (req[s].first_be[b]) begin
                            regs[req[s].reg_index][8*b +: 8] <= req[s].wr_data[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // config capture and LEDs, independent of the pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_num  <= 8'd0;
            user_led <= 4'd0;
        end else begin
            // tl_cfg_add 0 of function 0 carries the bus number
            if (tl_cfg_add == 5'd0 && tl_cfg_func == 2'd0) begin
                bus_num <= tl_cfg_ctl[7:0];
            end
            user_led <= regs[0][3:0];
        end
    end

endmodule

// File: tlp_req_decode.sv
// single-segment memory request header decoder
// classifies MRd/MWr, checks BAR, length and range, registers a req_t

`timescale 1ns/1ps

module tlp_req_decode #(
    parameter int SEG_DATA_WIDTH = 256
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              advance,
    input  core_pkg::rx_seg_t seg,
    output core_pkg::req_t    req
);

    // dwords one segment can carry
    localparam int SEG_DWORDS = SEG_DATA_WIDTH / 32;
    localparam int AP = core_pkg::BAR0_APERTURE;
    localparam int IW = core_pkg::REG_INDEX_WIDTH;

    pcie_tlp_pkg::tlp_dw0_t dw0;
    pcie_tlp_pkg::tlp_dw1_u dw1;
    logic [31:0]            addr_dw;
    logic [31:0]            data_dw;
    logic                   is_4dw;
    logic                   has_data;
    logic                   known;
    logic [2:0]             need_dws;
    logic                   fits;
    logic                   well_formed;
    logic [AP-1:0]          offset;
    logic                   bank_hit;
    logic [1:0]             be_offset;
    core_pkg::req_t         req_d;

    // header dwords sit in ascending 32-bit lanes
    assign dw0 = pcie_tlp_pkg::tlp_dw0_t'(seg.data[31:0]);
    // request view of dword 1
    assign dw1 = pcie_tlp_pkg::tlp_dw1_u'(seg.data[63:32]);

    assign is_4dw   = dw0.fmt_type[pcie_tlp_pkg::FMT_4DW_BIT];
    assign has_data = dw0.fmt_type[pcie_tlp_pkg::FMT_DATA_BIT];

    // only memory requests are handled here
    always_comb begin
        case (dw0.fmt_type)
            pcie_tlp_pkg::TLP_MRD32,
            pcie_tlp_pkg::TLP_MRD64,
            pcie_tlp_pkg::TLP_MWR32,
            pcie_tlp_pkg::TLP_MWR64: known = 1'b1;
            default:                 known = 1'b0;
        endcase
    end

    // 3DW: address in dw2, data in dw3
    // 4DW: low address in dw3, data in dw4
    assign addr_dw = is_4dw ? seg.data[127:96] : seg.data[95:64];
    assign data_dw = is_4dw ? seg.data[159:128] : seg.data[127:96];

    // header plus payload must fit in one segment
    assign need_dws = 3'd3 + {2'b00, is_4dw} + {2'b00, has_data};
    assign fits     = int'(need_dws) <= SEG_DWORDS;

    // single-beat, single-dword requests only
    assign well_formed = seg.valid && seg.sop && seg.eop && known && fits &&
                         (dw0.length == 10'd1);

    // offset inside the BAR0 aperture
    assign offset   = addr_dw[AP-1:0];
    assign bank_hit = (offset[AP-1:IW+2] == '0);

    // low address bits follow the first enabled byte
    always_comb begin
        casez (dw1.req.first_be)
            4'b???1: be_offset = 2'd0;
            4'b??10: be_offset = 2'd1;
            4'b?100: be_offset = 2'd2;
            4'b1000: be_offset = 2'd3;
            default: be_offset = 2'd0;
        endcase
    end

    always_comb begin
        req_d.valid        = well_formed;
        req_d.is_write     = has_data;
        req_d.hit          = (seg.bar_range == core_pkg::BAR0_RANGE) && bank_hit;
        req_d.reg_index    = offset[IW+1:2];
        req_d.lower_addr   = {offset[6:2], be_offset};
        req_d.requester_id = dw1.req.requester_id;
        req_d.tag          = dw1.req.tag;
        req_d.wr_data      = data_dw;
        req_d.first_be     = dw1.req.first_be;
    end

    // decode stage register, held with the pipeline
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req.valid <= 1'b0;
        end else if (advance) begin
            req <= req_d;
        end
    end

endmodule

// File: rx_seg_unpack.sv
// receive segment input register
// slices the flat H-tile rx buses into per-segment structs

`timescale 1ns/1ps

module rx_seg_unpack #(
    parameter int SEG_COUNT = 2,
    parameter int SEG_DATA_WIDTH = 256
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           advance,
    input  logic [SEG_COUNT*SEG_DATA_WIDTH-1:0]            rx_st_data,
    input  logic [SEG_COUNT-1:0]                           rx_st_sop,
    input  logic [SEG_COUNT-1:0]                           rx_st_eop,
    input  logic [SEG_COUNT-1:0]                           rx_st_valid,
    input  logic [SEG_COUNT*core_pkg::BAR_RANGE_WIDTH-1:0] rx_st_bar_range,
    output core_pkg::rx_seg_t [SEG_COUNT-1:0]              seg
);

    localparam int BRW = core_pkg::BAR_RANGE_WIDTH;

    // segment data zero-extended to the struct field
    logic [SEG_COUNT-1:0][core_pkg::SEG_DATA_MAX-1:0] data_ext;

    always_comb begin
        for (int i = 0; i < SEG_COUNT; i++) begin
            data_ext[i] = '0;
            data_ext[i][SEG_DATA_WIDTH-1:0] = rx_st_data[i*SEG_DATA_WIDTH +: SEG_DATA_WIDTH];
        end
    end

    // rx_st_ready equals advance, so a capture here is an accepted beat
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                seg[i].valid <= 1'b0;
            end
        end else if (advance) begin
            for (int i = 0; i < SEG_COUNT; i++) begin
                seg[i].valid     <= rx_st_valid[i];
                seg[i].data      <= data_ext[i];
                seg[i].sop       <= rx_st_sop[i];
                seg[i].eop       <= rx_st_eop[i];
                // which BAR the request hit
                seg[i].bar_range <= rx_st_bar_range[i*BRW +: BRW];
            end
        end
    end

endmodule

// File: core_pkg.sv
// segment stream structs, decoded request struct
// register bank and BAR0 constants

package core_pkg;

    // widest segment, narrower segments leave upper bits zero
    localparam int SEG_DATA_MAX = 256;
    localparam int BAR_RANGE_WIDTH = 3;

    // bar_range code for BAR0
    localparam logic [BAR_RANGE_WIDTH-1:0] BAR0_RANGE = 3'd0;
    // BAR0 aperture in address bits, upper bits are the BAR base
    localparam int BAR0_APERTURE = 12;

    // 16 registers of 32 bits
    localparam int REG_INDEX_WIDTH = 4;
    localparam int REG_COUNT = 2 ** REG_INDEX_WIDTH;

    // one receive segment
    typedef struct packed {
        logic [SEG_DATA_MAX-1:0]    data;
        logic                       sop;
        logic                       eop;
        logic                       valid;
        logic [BAR_RANGE_WIDTH-1:0] bar_range;
    } rx_seg_t;

    // one decoded single-dword request
    typedef struct packed {
        logic                       valid;
        logic                       is_write;
        logic                       hit;
        logic [REG_INDEX_WIDTH-1:0] reg_index;
        logic [6:0]                 lower_addr;
        logic [15:0]                requester_id;
        logic [7:0]                 tag;
        logic [31:0]                wr_data;
        logic [3:0]                 first_be;
    } req_t;

    // one transmit segment
    typedef struct packed {
        logic [SEG_DATA_MAX-1:0] data;
        logic                    sop;
        logic                    eop;
        logic                    valid;
    } tx_seg_t;

endpackage

// File: pcie_tlp_pkg.sv
// PCIe TLP header layouts, fmt/type codes and completion status codes
// header dword 1 union with request and completion views

package pcie_tlp_pkg;

    // fmt in bits 7:5, type in bits 4:0
    typedef enum logic [7:0] {
        TLP_MRD32 = 8'h00,
        TLP_MRD64 = 8'h20,
        TLP_MWR32 = 8'h40,
        TLP_MWR64 = 8'h60,
        TLP_CPL   = 8'h0a,
        TLP_CPLD  = 8'h4a
    } tlp_fmt_type_e;

    // bit positions inside fmt_type
    // fmt[0] selects the 4DW header, fmt[1] marks a payload
    localparam int FMT_4DW_BIT  = 5;
    localparam int FMT_DATA_BIT = 6;

    // completion status field
    typedef enum logic [2:0] {
        CPL_STATUS_SC = 3'b000,
        CPL_STATUS_UR = 3'b001
    } cpl_status_e;

    // header dword 0, common to all TLPs
    typedef struct packed {
        tlp_fmt_type_e fmt_type;
        logic          t9;
        logic [2:0]    tc;
        logic          t8;
        logic          attr2;
        logic          ln;
        logic          th;
        logic          td;
        logic          ep;
        logic [1:0]    attr;
        logic [1:0]    at;
        // in dwords
        logic [9:0]    length;
    } tlp_dw0_t;

    // request view of dword 1
    typedef struct packed {
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [3:0]  last_be;
        logic [3:0]  first_be;
    } req_dw1_t;

    // completion view of dword 1
    typedef struct packed {
        logic [15:0] completer_id;
        cpl_status_e status;
        logic        bcm;
        logic [11:0] byte_count;
    } cpl_dw1_t;

    // same header word, read as request or written as completion
    typedef union packed {
        req_dw1_t req;
        cpl_dw1_t cpl;
    } tlp_dw1_u;

    // completion dword 2
    typedef struct packed {
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic        rsvd;
        logic [6:0]  lower_addr;
    } cpl_dw2_t;

endpackage
